// File: src/gnn_pkg.sv
package gnn_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int VEC_LEN = 4;
  localparam int FEAT_W  = 8;
  localparam int ACC_W   = 19;  // Dot product plus shifted neighbour sum.
  localparam int OUT_W   = 16;
  localparam int CNT_W   = 32;
  localparam int FLAG_W  = 8;
  localparam int IDX_W   = $clog2(VEC_LEN);

  // Fixed edge weight of 4.
  localparam int NBR_SHIFT = 2;
  localparam int OUT_MAX   = (1 << OUT_W) - 1;

  typedef logic signed [FEAT_W-1:0]  feat_t;
  typedef logic [VEC_LEN*FEAT_W-1:0] vec_t;
  typedef logic [VEC_LEN-1:0]        mask_t;
  typedef logic signed [ACC_W-1:0]   acc_t;
  typedef logic [OUT_W-1:0]          out_t;
  typedef logic [CNT_W-1:0]          cnt_t;
  typedef logic [FLAG_W-1:0]         flags_t;
  typedef logic [IDX_W-1:0]          idx_t;

  ////////////////////
  // Debug flag bits
  ////////////////////

  localparam int FLG_SELF_VLD = 0;
  localparam int FLG_SELF_RDY = 1;
  localparam int FLG_NBR_VLD  = 2;
  localparam int FLG_NBR_RDY  = 3;
  localparam int FLG_COMB_VLD = 4;
  localparam int FLG_COMB_RDY = 5;
  localparam int FLG_SAT      = 6;

  ////////////////////
  // State machines
  ////////////////////

  typedef enum logic [1:0] {CTRL_IDLE, CTRL_BUSY, CTRL_ACK} ctrl_state_t;

  typedef enum logic [1:0] {MAC_IDLE, MAC_RUN, MAC_DONE} mac_state_t;

endpackage

// File: src/job_ctrl.sv
module job_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req_i,
  input  gnn_pkg::vec_t  feat_i,
  input  gnn_pkg::vec_t  nbr_i,
  input  gnn_pkg::mask_t mask_i,
  input  logic           comb_vld_i,
  input  gnn_pkg::out_t  comb_result_i,
  input  logic           comb_sat_i,
  output logic           ack_o,
  output gnn_pkg::out_t  result_o,
  output logic           sat_o,
  output logic           start_o,
  output gnn_pkg::vec_t  feat_o,
  output gnn_pkg::vec_t  nbr_o,
  output gnn_pkg::mask_t mask_o,
  output logic           comb_rdy_o
);

  import gnn_pkg::*;

  ctrl_state_t state_q;
  logic        take_job;
  logic        take_res;

  assign take_job   = (state_q == CTRL_IDLE) && req_i;
  assign take_res   = comb_vld_i && comb_rdy_o;
  assign comb_rdy_o = (state_q == CTRL_BUSY);  // No new result while ack held.
  assign ack_o      = (state_q == CTRL_ACK);

  ////////////////////
  // Handshake FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CTRL_IDLE;
      start_o <= 1'b0;
    end else begin
      start_o <= take_job;  // One pulse per job.
      case (state_q)
        CTRL_IDLE: begin
          if (take_job) begin
            state_q <= CTRL_BUSY;
          end
        end
        CTRL_BUSY: begin
          if (take_res) begin
            state_q <= CTRL_ACK;
          end
        end
        CTRL_ACK: begin
          if (!req_i) begin
            state_q <= CTRL_IDLE;  // Ack drops next cycle.
          end
        end
        default: begin
          state_q <= CTRL_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Operand and result latches
  ////////////////////

  always_ff @(posedge clk) begin
    if (take_job) begin
      feat_o <= feat_i;
      nbr_o  <= nbr_i;
      mask_o <= mask_i;
    end
    if (take_res) begin
      result_o <= comb_result_i;
      sat_o    <= comb_sat_i;
    end
  end

endmodule

// File: src/self_transform.sv
module self_transform (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start_i,
  input  gnn_pkg::vec_t feat_i,
  input  gnn_pkg::vec_t weight_i,
  input  logic          rdy_i,
  output logic          vld_o,
  output gnn_pkg::acc_t term_o
);

  import gnn_pkg::*;

  mac_state_t                 state_q;
  idx_t                       idx_q;
  idx_t                       sel;
  feat_t                      f_elem;
  feat_t                      w_elem;
  logic signed [2*FEAT_W-1:0] prod;
  acc_t                       acc_q;
  logic                       first;

  // Element 0 is taken on the start cycle itself.
  assign first  = (state_q == MAC_IDLE) && start_i;
  assign sel    = (state_q == MAC_RUN) ? idx_q : '0;
  assign f_elem = feat_i[sel*FEAT_W +: FEAT_W];
  assign w_elem = weight_i[sel*FEAT_W +: FEAT_W];
  assign prod   = f_elem * w_elem;  // Signed 8x8.

  assign vld_o  = (state_q == MAC_DONE);
  assign term_o = acc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MAC_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        MAC_IDLE: begin
          if (first) begin
            idx_q   <= idx_t'(1);
            state_q <= MAC_RUN;
          end
        end
        MAC_RUN: begin
          idx_q <= idx_q + 1'b1;
          if (idx_q == idx_t'(VEC_LEN - 1)) begin
            state_q <= MAC_DONE;  // Last product this cycle.
          end
        end
        MAC_DONE: begin
          if (rdy_i) begin
            state_q <= MAC_IDLE;
          end
        end
        default: begin
          state_q <= MAC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (first) begin
      acc_q <= acc_t'(prod);
    end else if (state_q == MAC_RUN) begin
      acc_q <= acc_q + acc_t'(prod);
    end
  end

endmodule

// File: src/neighbor_gather.sv
module neighbor_gather (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start_i,
  input  gnn_pkg::vec_t  nbr_i,
  input  gnn_pkg::mask_t mask_i,
  input  logic           rdy_i,
  output logic           vld_o,
  output gnn_pkg::acc_t  term_o
);

  import gnn_pkg::*;

  mac_state_t state_q;
  mask_t      work_q;
  mask_t      src;
  mask_t      work_nxt;
  idx_t       pick;
  feat_t      n_elem;
  acc_t       sum_q;
  acc_t       base;
  acc_t       sum_nxt;
  acc_t       term_q;
  logic       step;
  logic       last;

  assign step = ((state_q == MAC_IDLE) && start_i) || (state_q == MAC_RUN);

  ////////////////////
  // Lowest set bit
  ////////////////////

  always_comb begin
    src  = (state_q == MAC_RUN) ? work_q : mask_i;  // Mask straight in on start.
    base = (state_q == MAC_RUN) ? sum_q : '0;
    pick = '0;
    for (int i = VEC_LEN - 1; i >= 0; i--) begin
      if (src[i]) begin
        pick = idx_t'(i);
      end
    end
    work_nxt = src & (src - 1'b1);  // Clear that bit.
    n_elem   = nbr_i[pick*FEAT_W +: FEAT_W];
    sum_nxt  = (src != '0) ? base + acc_t'(n_elem) : base;
  end

  assign last   = (work_nxt == '0);
  assign vld_o  = (state_q == MAC_DONE);
  assign term_o = term_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MAC_IDLE;
    end else begin
      case (state_q)
        MAC_IDLE: begin
          if (start_i) begin
            state_q <= last ? MAC_DONE : MAC_RUN;
          end
        end
        MAC_RUN: begin
          if (last) begin
            state_q <= MAC_DONE;
          end
        end
        MAC_DONE: begin
          if (rdy_i) begin
            state_q <= MAC_IDLE;
          end
        end
        default: begin
          state_q <= MAC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      work_q <= work_nxt;
      sum_q  <= sum_nxt;
      if (last) begin
        term_q <= sum_nxt <<< NBR_SHIFT;  // Edge weight.
      end
    end
  end

endmodule

// File: src/node_combine.sv
module node_combine (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          self_vld_i,
  input  gnn_pkg::acc_t self_term_i,
  input  logic          nbr_vld_i,
  input  gnn_pkg::acc_t nbr_term_i,
  input  logic          rdy_i,
  output logic          self_rdy_o,
  output logic          nbr_rdy_o,
  output logic          vld_o,
  output gnn_pkg::out_t result_o,
  output logic          sat_o
);

  import gnn_pkg::*;

  acc_t self_q;
  acc_t nbr_q;
  acc_t self_nxt;
  acc_t nbr_nxt;
  acc_t sum;
  out_t res_nxt;
  logic sat_nxt;
  logic self_held_q;
  logic nbr_held_q;
  logic both;

  // Each term is acknowledged on its own.
  assign self_rdy_o = self_vld_i && !self_held_q;
  assign nbr_rdy_o  = nbr_vld_i && !nbr_held_q;

  assign self_nxt = self_rdy_o ? self_term_i : self_q;
  assign nbr_nxt  = nbr_rdy_o ? nbr_term_i : nbr_q;
  assign both     = (self_held_q || self_rdy_o) && (nbr_held_q || nbr_rdy_o) && !vld_o;
  assign sum      = self_nxt + nbr_nxt;

  ////////////////////
  // ReLU and clamp
  ////////////////////

  always_comb begin
    res_nxt = out_t'(sum);
    sat_nxt = 1'b0;
    if (sum < 0) begin
      res_nxt = '0;
    end else if (sum > OUT_MAX) begin
      res_nxt = out_t'(OUT_MAX);
      sat_nxt = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      self_held_q <= 1'b0;
      nbr_held_q  <= 1'b0;
      vld_o       <= 1'b0;
    end else if (both) begin
      self_held_q <= 1'b0;
      nbr_held_q  <= 1'b0;
      vld_o       <= 1'b1;
    end else begin
      if (self_rdy_o) begin
        self_held_q <= 1'b1;
      end
      if (nbr_rdy_o) begin
        nbr_held_q <= 1'b1;
      end
      if (vld_o && rdy_i) begin
        vld_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    self_q <= self_nxt;
    nbr_q  <= nbr_nxt;
    if (both) begin
      result_o <= res_nxt;
      sat_o    <= sat_nxt;
    end
  end

endmodule

// File: src/hs_debugger.sv
module hs_debugger (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            self_vld_i,
  input  logic            self_rdy_i,
  input  logic            nbr_vld_i,
  input  logic            nbr_rdy_i,
  input  logic            comb_vld_i,
  input  logic            comb_rdy_i,
  input  logic            sat_i,
  output gnn_pkg::flags_t debug_flags_o,
  output gnn_pkg::cnt_t   debug_jobs_o
);

  import gnn_pkg::*;

  flags_t live;
  flags_t seen;
  flags_t seen_q;
  cnt_t   jobs;
  cnt_t   jobs_q;
  logic   xfer;

  ////////////////////
  // Sticky flags
  ////////////////////

  always_comb begin
    live               = '0;  // Bit 7 stays clear.
    live[FLG_SELF_VLD] = self_vld_i;
    live[FLG_SELF_RDY] = self_rdy_i;
    live[FLG_NBR_VLD]  = nbr_vld_i;
    live[FLG_NBR_RDY]  = nbr_rdy_i;
    live[FLG_COMB_VLD] = comb_vld_i;
    live[FLG_COMB_RDY] = comb_rdy_i;
    live[FLG_SAT]      = sat_i && comb_vld_i;  // Only a presented result.
  end

  assign seen = seen_q | live;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_q <= '0;
    end else begin
      seen_q <= seen;
    end
  end

  ////////////////////
  // Job counter
  ////////////////////

  assign xfer = comb_vld_i && comb_rdy_i;
  assign jobs = xfer ? jobs_q + 1'b1 : jobs_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      jobs_q <= '0;
    end else begin
      jobs_q <= jobs;
    end
  end

  assign debug_flags_o = seen_q;
  assign debug_jobs_o  = jobs_q;

endmodule

// File: src/gnn_node_top.sv
module gnn_node_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,
  input  gnn_pkg::vec_t   feat_i,
  input  gnn_pkg::vec_t   nbr_i,
  input  gnn_pkg::mask_t  mask_i,
  input  gnn_pkg::vec_t   weight_i,
  output logic            ack_o,
  output gnn_pkg::out_t   result_o,
  output logic            sat_o,
  output gnn_pkg::flags_t debug_flags_o,
  output gnn_pkg::cnt_t   debug_jobs_o
);

  import gnn_pkg::*;

  logic  start;
  vec_t  feat;
  vec_t  nbr;
  mask_t mask;
  logic  self_vld;
  logic  self_rdy;
  acc_t  self_term;
  logic  nbr_vld;
  logic  nbr_rdy;
  acc_t  nbr_term;
  logic  comb_vld;
  logic  comb_rdy;
  out_t  comb_result;
  logic  comb_sat;

  job_ctrl u_job_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .feat_i        (feat_i),
    .nbr_i         (nbr_i),
    .mask_i        (mask_i),
    .comb_vld_i    (comb_vld),
    .comb_result_i (comb_result),
    .comb_sat_i    (comb_sat),
    .ack_o         (ack_o),
    .result_o      (result_o),
    .sat_o         (sat_o),
    .start_o       (start),
    .feat_o        (feat),
    .nbr_o         (nbr),
    .mask_o        (mask),
    .comb_rdy_o    (comb_rdy)
  );

  // Both terms run side by side.
  self_transform u_self_transform (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (start),
    .feat_i   (feat),
    .weight_i (weight_i),
    .rdy_i    (self_rdy),
    .vld_o    (self_vld),
    .term_o   (self_term)
  );

  neighbor_gather u_neighbor_gather (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start),
    .nbr_i   (nbr),
    .mask_i  (mask),
    .rdy_i   (nbr_rdy),
    .vld_o   (nbr_vld),
    .term_o  (nbr_term)
  );

  node_combine u_node_combine (
    .clk         (clk),
    .rst_n       (rst_n),
    .self_vld_i  (self_vld),
    .self_term_i (self_term),
    .nbr_vld_i   (nbr_vld),
    .nbr_term_i  (nbr_term),
    .rdy_i       (comb_rdy),
    .self_rdy_o  (self_rdy),
    .nbr_rdy_o   (nbr_rdy),
    .vld_o       (comb_vld),
    .result_o    (comb_result),
    .sat_o       (comb_sat)
  );

  hs_debugger u_hs_debugger (
    .clk           (clk),
    .rst_n         (rst_n),
    .self_vld_i    (self_vld),
    .self_rdy_i    (self_rdy),
    .nbr_vld_i     (nbr_vld),
    .nbr_rdy_i     (nbr_rdy),
    .comb_vld_i    (comb_vld),
    .comb_rdy_i    (comb_rdy),
    .sat_i         (comb_sat),
    .debug_flags_o (debug_flags_o),
    .debug_jobs_o  (debug_jobs_o)
  );

endmodule

// File: bench/gnn_node_tb.sv
module gnn_node_tb;

  import gnn_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int RAND_JOBS    = 200;
  localparam int DIR_JOBS     = 3;
  localparam int JOB_CYCLES   = 20;
  localparam int CYCLE_LIMIT  = (RAND_JOBS + DIR_JOBS) * JOB_CYCLES + RESET_CYCLES;

  logic   clk;
  logic   rst_n;
  logic   req_i;
  vec_t   feat_i;
  vec_t   nbr_i;
  mask_t  mask_i;
  vec_t   weight_i;
  logic   ack_o;
  out_t   result_o;
  logic   sat_o;
  flags_t debug_flags_o;
  cnt_t   debug_jobs_o;

  logic [31:0] lfsr;
  out_t        exp_result;
  logic        exp_sat;
  logic        any_sat;
  cnt_t        handshakes;
  int          cycle_cnt;
  logic        ack_seen;
  logic        req_seen;

  gnn_node_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .feat_i        (feat_i),
    .nbr_i         (nbr_i),
    .mask_i        (mask_i),
    .weight_i      (weight_i),
    .ack_o         (ack_o),
    .result_o      (result_o),
    .sat_o         (sat_o),
    .debug_flags_o (debug_flags_o),
    .debug_jobs_o  (debug_jobs_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1);
  endtask

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};  // One step per bit.
    end
  endtask

  // Returns {sat, result}.
  function automatic logic [16:0] expected_node(input vec_t f, input vec_t n,
                                                input mask_t m, input vec_t w);
    logic signed [7:0] fe;
    logic signed [7:0] we;
    logic signed [7:0] ne;
    int                dot;
    int                nsum;
    int                total;
    logic [16:0]       r;
    dot  = 0;
    nsum = 0;
    for (int i = 0; i < VEC_LEN; i++) begin
      fe  = f[i*8 +: 8];
      we  = w[i*8 +: 8];
      ne  = n[i*8 +: 8];
      dot = dot + int'(fe) * int'(we);
      if (m[i]) begin
        nsum = nsum + int'(ne);
      end
    end
    total = dot + nsum * 4;  // Edge weight of 4.
    if (total < 0) begin
      r = {1'b0, 16'd0};
    end else if (total > 65535) begin
      r = {1'b1, 16'hffff};
    end else begin
      r = {1'b0, total[15:0]};
    end
    return r;
  endfunction

  task automatic run_job(input vec_t f, input vec_t n, input mask_t m, input vec_t w,
                         input int hold);
    logic [16:0] exp_bits;
    exp_bits = expected_node(f, n, m, w);
    @(posedge clk);
    exp_result = exp_bits[15:0];
    exp_sat    = exp_bits[16];
    any_sat    = any_sat | exp_bits[16];
    feat_i   <= f;
    nbr_i    <= n;
    mask_i   <= m;
    weight_i <= w;
    req_i    <= 1'b1;
    do begin
      @(negedge clk);
    end while (!ack_o);
    repeat (hold) @(posedge clk);  // Req stays high past ack.
    @(posedge clk);
    req_i <= 1'b0;
    do begin
      @(negedge clk);
    end while (ack_o);
  endtask

  task automatic run_random_job();
    logic [31:0] r;
    vec_t        f;
    vec_t        n;
    vec_t        w;
    mask_t       m;
    int          hold;
    draw_bits(32, r);
    f = r;
    draw_bits(32, r);
    n = r;
    draw_bits(32, r);
    w = r;
    draw_bits(4, r);
    m = r[3:0];
    draw_bits(4, r);
    hold = int'(r[3:0]) % 11;
    run_job(f, n, m, w, hold);
  endtask

  ////////////////////
  // Comparison
  ////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (ack_o && !ack_seen) begin
        handshakes = handshakes + 1;
      end
      if (ack_o) begin
        assert (result_o == exp_result)
          else stop_with_error($sformatf("** Error at time %0t: result_o is %0d, expected %0d",
                                         $time, result_o, exp_result));
        assert (sat_o == exp_sat)
          else stop_with_error($sformatf("** Error at time %0t: sat_o is %0b, expected %0b",
                                         $time, sat_o, exp_sat));
      end
      if (ack_seen && !ack_o) begin
        assert (!req_seen)
          else stop_with_error($sformatf(
            "Protocol error at time %0t: ack_o fell while req_i was high", $time));
      end
      assert (debug_jobs_o == handshakes)
        else stop_with_error($sformatf("** Error at time %0t: debug_jobs_o is %0d, expected %0d",
                                       $time, debug_jobs_o, handshakes));
      ack_seen = ack_o;
      req_seen = req_i;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    stop_with_error($sformatf("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n      = 1'b0;
    req_i      = 1'b0;
    feat_i     = '0;
    nbr_i      = '0;
    mask_i     = '0;
    weight_i   = '0;
    lfsr       = 32'hee3206dd;
    exp_result = '0;
    exp_sat    = 1'b0;
    any_sat    = 1'b0;
    handshakes = '0;
    ack_seen   = 1'b0;
    req_seen   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (ack_o == 1'b0 && debug_flags_o == '0 && debug_jobs_o == '0)
      else stop_with_error($sformatf("** Error at time %0t: outputs not idle after reset", $time));

    run_job(32'h04030201, 32'h80808080, 4'h0, 32'h08070605, 2);  // Self term only.
    run_job(32'h0a0a0a0a, 32'hfbfbfbfb, 4'hf, 32'hfdfdfdfd, 0);  // Negative sum.
    run_job(32'h80808080, 32'h7f7f7f7f, 4'hf, 32'h80808080, 5);  // Saturates.
    repeat (RAND_JOBS) run_random_job();

    @(negedge clk);
    assert (debug_jobs_o == cnt_t'(RAND_JOBS + DIR_JOBS))
      else stop_with_error($sformatf("** Error at time %0t: debug_jobs_o is %0d, expected %0d",
                                     $time, debug_jobs_o, RAND_JOBS + DIR_JOBS));
    assert (debug_flags_o[5:0] == 6'h3f)
      else stop_with_error($sformatf("** Error at time %0t: handshake flags are %0h",
                                     $time, debug_flags_o[5:0]));
    assert (debug_flags_o[6] == any_sat && debug_flags_o[7] == 1'b0)
      else stop_with_error($sformatf("** Error at time %0t: flag word is %0h, sat expected %0b",
                                     $time, debug_flags_o, any_sat));
    $display("All checks passed");
    $finish;
  end

endmodule

// File: sim.f
src/gnn_pkg.sv
src/job_ctrl.sv
src/self_transform.sv
src/neighbor_gather.sv
src/node_combine.sv
src/hs_debugger.sv
src/gnn_node_top.sv
bench/gnn_node_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the GNN node testbench with Verilator.
rm -rf obj_dir sim.log
verilator --binary --timing --top-module gnn_node_tb -f sim.f -o gnn_node_sim &&
  ./obj_dir/gnn_node_sim > sim.log 2>&1
[ -f sim.log ] || { echo "Build failed"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0
